/* design/crc32_engine.sv */
`timescale 1ns/1ps

module crc32_engine import eth_rx_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  crc_init,         // Restart at delimiter
    input  logic  crc_en,           // Fold crc_byte into the register
    input  byte_t crc_byte,
    output crc_t  crc_next          // Register value with crc_byte included
);

    crc_t crc_q;                    // Running CRC

    // LSB-first byte update, one shift per bit
    function automatic crc_t crc_byte_update(crc_t crc, byte_t b);
        crc_t c;
        c = crc ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0])
                c = (c >> 1) ^ CRC_POLY_REFL;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // Look-ahead so the parser can compare in the cycle of the last payload byte
    assign crc_next = crc_byte_update(crc_q, crc_byte);

    always_ff @(posedge clk) begin
        if (!reset_n || crc_init) begin
            crc_q <= CRC_INIT;              // Start value for each frame
        end else if (crc_en) begin
            crc_q <= crc_next;
        end
    end

endmodule

/* design/eth_rx_pkg.sv */
package eth_rx_pkg;

    // Basic widths
    typedef logic [7:0]  byte_t;    // One octet of frame data
    typedef logic [31:0] crc_t;     // CRC-32 register value

    // Byte as it arrives from the PHY side, one per clock
    typedef struct packed {
        byte_t data;                // Received octet
        logic  dv;                  // Data valid
        logic  er;                  // PHY error
    } rx_byte_t;

    // One output stream beat
    typedef struct packed {
        byte_t data;                // Payload octet
        logic  last;                // Final payload byte of the frame
        logic  user;                // Bad frame, only meaningful with last
    } axis_beat_t;

    // How a frame ended
    typedef enum logic [1:0] {
        RX_GOOD    = 2'd0,          // FCS matched, no PHY error
        RX_CRC_BAD = 2'd1,          // FCS mismatch
        RX_PHY_ERR = 2'd2           // er seen, or runt frame
    } rx_status_t;

    // Frame end report from parser to statistics, paired with frame_done
    typedef struct packed {
        rx_status_t status;
    } frame_end_t;

    // Parser FSM
    typedef enum logic [1:0] {
        SEEK_SFD   = 2'd0,          // Hunting for the delimiter
        IN_FRAME   = 2'd1,          // Forwarding payload
        DROP_FRAME = 2'd2           // Discarding rest of an errored frame
    } parser_state_t;

    localparam byte_t ETH_SFD       = 8'hD5;
    localparam crc_t  CRC_INIT      = 32'hFFFF_FFFF;
    localparam crc_t  CRC_POLY_REFL = 32'hEDB8_8320;   // Bit-reversed 0x04C11DB7

endpackage

/* design/eth_rx_top.sv */
`timescale 1ns/1ps

module eth_rx_top import eth_rx_pkg::*; #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  rx_byte_t             rx_in,             // One byte per clock from the PHY side
    output logic                 m_axis_valid,
    output axis_beat_t           m_axis,
    output logic [CNT_WIDTH-1:0] good_frames,
    output logic [CNT_WIDTH-1:0] crc_err_frames,
    output logic [CNT_WIDTH-1:0] phy_err_frames,
    output logic [CNT_WIDTH-1:0] good_bytes
);

    logic       crc_init;
    logic       crc_en;
    byte_t      crc_byte;
    crc_t       crc_next;
    logic       frame_done;
    frame_end_t frame_end;

    rx_frame_parser rx_frame_parser_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .rx_in        (rx_in),
        .crc_init     (crc_init),
        .crc_en       (crc_en),
        .crc_byte     (crc_byte),
        .crc_next     (crc_next),
        .m_axis_valid (m_axis_valid),
        .m_axis       (m_axis),
        .frame_done   (frame_done),
        .frame_end    (frame_end)
    );

    crc32_engine crc32_engine_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .crc_init (crc_init),
        .crc_en   (crc_en),
        .crc_byte (crc_byte),
        .crc_next (crc_next)
    );

    // Every output beat is one payload byte for the statistics
    rx_frame_stats #(
        .CNT_WIDTH (CNT_WIDTH)
    ) rx_frame_stats_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .beat_valid     (m_axis_valid),
        .beat_last      (m_axis.last),
        .frame_done     (frame_done),
        .frame_end      (frame_end),
        .good_frames    (good_frames),
        .crc_err_frames (crc_err_frames),
        .phy_err_frames (phy_err_frames),
        .good_bytes     (good_bytes)
    );

endmodule

/* design/rx_frame_parser.sv */
`timescale 1ns/1ps

module rx_frame_parser import eth_rx_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  rx_byte_t   rx_in,
    output logic       crc_init,
    output logic       crc_en,
    output byte_t      crc_byte,
    input  crc_t       crc_next,
    output logic       m_axis_valid,
    output axis_beat_t m_axis,
    output logic       frame_done,
    output frame_end_t frame_end
);

    localparam int DEPTH = 5;       // Four FCS bytes plus the byte being judged

    rx_byte_t      line_q [DEPTH];  // Delay line, [0] newest, [DEPTH-1] oldest
    parser_state_t state_q, state_d;
    logic          armed_q;         // Gap seen at the line tail since last frame
    logic          runt_q;          // Frame just opened has under five bytes
    logic          sfd_hit;
    logic          full_len;
    logic          fcs_ok;
    logic          fcs_phy;
    logic [31:0]   fcs_rx;
    logic          beat_valid_d;
    axis_beat_t    beat_d;
    logic          done_d;
    frame_end_t    end_d;

    // Shift register, flags cleared in reset so no stale dv survives
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                line_q[i].dv <= 1'b0;
                line_q[i].er <= 1'b0;
            end
        end else begin
            line_q[0] <= rx_in;
            for (int i = 1; i < DEPTH; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // Delimiter at the tail of the line, only after a dv gap has passed through
    // so FCS or dropped bytes of the previous frame cannot look like a new SFD
    assign sfd_hit = (state_q == SEEK_SFD) && armed_q && line_q[DEPTH-1].dv
                     && (line_q[DEPTH-1].data == ETH_SFD);

    // Bytes 1..4 sit in stages 3..0 and byte 5 is on the input when SFD is at stage 4
    assign full_len = rx_in.dv && line_q[0].dv && line_q[1].dv
                      && line_q[2].dv && line_q[3].dv;

    // FCS goes LSB first, so the oldest of the four is the low byte
    assign fcs_rx  = {line_q[0].data, line_q[1].data, line_q[2].data, line_q[3].data};
    assign fcs_ok  = (fcs_rx == ~crc_next);
    assign fcs_phy = (line_q[0].dv & line_q[0].er) | (line_q[1].dv & line_q[1].er)
                   | (line_q[2].dv & line_q[2].er) | (line_q[3].dv & line_q[3].er);

    assign crc_init = sfd_hit;
    assign crc_byte = line_q[DEPTH-1].data;     // CRC always looks at the byte being emitted

    always_comb begin
        state_d      = state_q;
        beat_valid_d = 1'b0;
        beat_d.data  = line_q[DEPTH-1].data;
        beat_d.last  = 1'b0;
        beat_d.user  = 1'b0;
        done_d       = 1'b0;
        end_d.status = RX_GOOD;
        crc_en       = 1'b0;

        case (state_q)
            SEEK_SFD: begin
                if (sfd_hit)
                    state_d = IN_FRAME;
            end

            IN_FRAME: begin
                if (runt_q) begin
                    // Too short for payload plus FCS, report and emit nothing
                    done_d       = 1'b1;
                    end_d.status = RX_PHY_ERR;
                    state_d      = SEEK_SFD;
                end else begin
                    beat_valid_d = 1'b1;
                    crc_en       = 1'b1;
                    if (line_q[DEPTH-1].dv && line_q[DEPTH-1].er) begin
                        beat_d.last  = 1'b1;    // Errored byte closes the frame
                        beat_d.user  = 1'b1;
                        done_d       = 1'b1;
                        end_d.status = RX_PHY_ERR;
                        // Skip DROP_FRAME when dv is already gone
                        state_d      = rx_in.dv ? DROP_FRAME : SEEK_SFD;
                    end else if (!rx_in.dv) begin
                        // End of frame, stages 0..3 hold the FCS
                        beat_d.last = 1'b1;
                        done_d      = 1'b1;
                        if (fcs_phy)
                            end_d.status = RX_PHY_ERR;
                        else if (!fcs_ok)
                            end_d.status = RX_CRC_BAD;
                        beat_d.user = !(!fcs_phy && fcs_ok);
                        state_d     = SEEK_SFD;
                    end
                end
            end

            DROP_FRAME: begin
                if (!rx_in.dv)
                    state_d = SEEK_SFD;     // Wait out the rest of the bad frame
            end

            default: state_d = SEEK_SFD;
        endcase
    end

    // Control state and strobes
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q      <= SEEK_SFD;
            armed_q      <= 1'b0;
            runt_q       <= 1'b0;
            m_axis_valid <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            state_q      <= state_d;
            runt_q       <= sfd_hit && !full_len;   // Only high in first IN_FRAME cycle
            m_axis_valid <= beat_valid_d;
            frame_done   <= done_d;
            if (state_q != SEEK_SFD)
                armed_q <= 1'b0;
            else if (!line_q[DEPTH-1].dv)
                armed_q <= 1'b1;                    // Inter-frame gap reached the tail
        end
    end

    // Output register for the payload side
    always_ff @(posedge clk) begin
        m_axis    <= beat_d;
        frame_end <= end_d;
    end

    // A closing beat is a real beat and carries a byte that arrived with dv high
    a_last_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
        m_axis.last |-> m_axis_valid && $past(line_q[DEPTH-1].dv));

    // Report is registered, so the deciding state is the one a cycle earlier
    a_done_not_seek: assert property (@(posedge clk) disable iff (!reset_n)
        frame_done |-> $past(state_q) != SEEK_SFD);

endmodule

/* design/rx_frame_stats.sv */
`timescale 1ns/1ps

module rx_frame_stats import eth_rx_pkg::*; #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 beat_valid,
    input  logic                 beat_last,
    input  logic                 frame_done,
    input  frame_end_t           frame_end,
    output logic [CNT_WIDTH-1:0] good_frames,
    output logic [CNT_WIDTH-1:0] crc_err_frames,
    output logic [CNT_WIDTH-1:0] phy_err_frames,
    output logic [CNT_WIDTH-1:0] good_bytes
);

    typedef logic [CNT_WIDTH-1:0] cnt_t;

    cnt_t acc_q;                    // Beats of the frame in progress
    cnt_t frame_bytes;              // Frame total including this cycle's beat

    // Last beat and frame_done share a cycle, so count that beat too
    assign frame_bytes = acc_q + cnt_t'(beat_valid);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            acc_q          <= '0;
            good_frames    <= '0;
            crc_err_frames <= '0;
            phy_err_frames <= '0;
            good_bytes     <= '0;
        end else begin
            if (frame_done || (beat_valid && beat_last))
                acc_q <= '0;                        // Next frame starts from zero
            else if (beat_valid)
                acc_q <= acc_q + 1'b1;

            if (frame_done) begin
                case (frame_end.status)
                    RX_GOOD: begin
                        good_frames <= good_frames + 1'b1;
                        good_bytes  <= good_bytes + frame_bytes;   // Wraps
                    end
                    RX_CRC_BAD: crc_err_frames <= crc_err_frames + 1'b1;
                    RX_PHY_ERR: phy_err_frames <= phy_err_frames + 1'b1;
                    default: ;
                endcase
            end
        end
    end

    a_status_legal: assert property (@(posedge clk) disable iff (!reset_n)
        frame_done |-> frame_end.status inside {RX_GOOD, RX_CRC_BAD, RX_PHY_ERR});

endmodule

/* filelist.f */
design/eth_rx_pkg.sv
design/crc32_engine.sv
design/rx_frame_parser.sv
design/rx_frame_stats.sv
design/eth_rx_top.sv
sim/rx_checker.sv
sim/tb_eth_rx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Ethernet RX testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_eth_rx -o tb_eth_rx
./obj_dir/tb_eth_rx > sim.log
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* sim/rx_checker.sv */
`timescale 1ns/1ps

module rx_checker import eth_rx_pkg::*; #(
    parameter int CNT_WIDTH = 16
) (
    input logic                 clk,
    input logic                 reset_n,
    input rx_byte_t             rx_in,
    input logic                 m_axis_valid,
    input axis_beat_t           m_axis,
    input logic [CNT_WIDTH-1:0] good_frames,
    input logic [CNT_WIDTH-1:0] crc_err_frames,
    input logic [CNT_WIDTH-1:0] phy_err_frames,
    input logic [CNT_WIDTH-1:0] good_bytes
);

    byte_t      frame_q[$];             // Bytes after the delimiter
    axis_beat_t exp_q[$];               // Beats the DUT still owes
    axis_beat_t got_q[$];               // Beats not yet matched
    logic       in_frame  = 1'b0;
    logic       armed     = 1'b0;       // Gap seen since the last frame began
    int         first_err = -1;         // Index of the first er byte
    int         idle      = 0;          // Cycles since dv was last high
    int         n_good    = 0;
    int         n_crc     = 0;
    int         n_phy     = 0;
    int         n_bytes   = 0;
    int         errors    = 0;
    int         checks    = 0;

    // FCS over the first len bytes, one bit at a time, LSB first
    function automatic crc_t fcs_ref(input int len);
        crc_t c;
        c = CRC_INIT;
        for (int i = 0; i < len; i++) begin
            for (int k = 0; k < 8; k++)
                c = (c >> 1) ^ ((c[0] ^ frame_q[i][k]) ? CRC_POLY_REFL : 32'h0);
        end
        return ~c;
    endfunction

    task automatic report_diff(input string name, input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("CHECK FAILED at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    endtask

    task automatic match_beat(input axis_beat_t e, input axis_beat_t a);
        checks++;
        if (a.data !== e.data) report_diff("m_axis.data", 32'(e.data), 32'(a.data));
        if (a.last !== e.last) report_diff("m_axis.last", 32'(e.last), 32'(a.last));
        if (a.user !== e.user) report_diff("m_axis.user", 32'(e.user), 32'(a.user));
    endtask

    task automatic verify_counter(input string name, input int exp,
                                  input logic [CNT_WIDTH-1:0] act);
        logic [CNT_WIDTH-1:0] exp_w;
        exp_w = exp[CNT_WIDTH-1:0];     // Counters wrap
        checks++;
        if (act !== exp_w) report_diff(name, 32'(exp_w), 32'(act));
    endtask

    // Frame ended at the input, queue its beats and book its status
    task automatic close_frame();
        int         n;
        int         last_i;
        logic       bad;
        axis_beat_t b;
        n = frame_q.size();
        if (n < 5) begin
            n_phy++;                    // Runt gives no beats
            return;
        end
        last_i = (first_err >= 0 && first_err <= n - 5) ? first_err : n - 5;
        bad    = 1'b1;
        if (first_err >= 0) begin
            n_phy++;
        end else if ({frame_q[n-1], frame_q[n-2], frame_q[n-3], frame_q[n-4]} != fcs_ref(n - 4)) begin
            n_crc++;
        end else begin
            n_good++;
            n_bytes += n - 4;
            bad      = 1'b0;
        end
        for (int i = 0; i <= last_i; i++) begin
            b.data = frame_q[i];
            b.last = (i == last_i);
            b.user = (i == last_i) && bad;
            exp_q.push_back(b);
        end
    endtask

    // Line quiet long enough for every beat and counter update to land
    task automatic idle_audit();
        if (exp_q.size() > 0) begin
            errors++;
            $display("%0t: %0d expected beats never left the DUT", $time, exp_q.size());
            exp_q.delete();
        end
        if (got_q.size() > 0) begin
            errors++;
            $display("%0t: DUT sent %0d beats that belong to no frame", $time, got_q.size());
            got_q.delete();
        end
        verify_counter("good_frames", n_good, good_frames);
        verify_counter("crc_err_frames", n_crc, crc_err_frames);
        verify_counter("phy_err_frames", n_phy, phy_err_frames);
        verify_counter("good_bytes", n_bytes, good_bytes);
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            in_frame = 1'b0;
            armed    = 1'b0;
            idle     = 0;
        end else begin
            if (in_frame && rx_in.dv) begin
                if (rx_in.er && first_err < 0)
                    first_err = frame_q.size();
                frame_q.push_back(rx_in.data);
            end else if (in_frame) begin
                close_frame();
                in_frame = 1'b0;
            end else if (armed && rx_in.dv && rx_in.data == ETH_SFD) begin
                in_frame  = 1'b1;       // Delimiter after a gap opens a frame
                armed     = 1'b0;
                first_err = -1;
                frame_q.delete();
            end
            if (!rx_in.dv)
                armed = 1'b1;
            if (m_axis_valid)
                got_q.push_back(m_axis);
            while (got_q.size() > 0 && exp_q.size() > 0)
                match_beat(exp_q.pop_front(), got_q.pop_front());
            idle = rx_in.dv ? 0 : idle + 1;
            if (idle > 0 && idle % 12 == 0)
                idle_audit();
        end
    end

endmodule

/* sim/tb_eth_rx.sv */
`timescale 1ns/1ps

module tb_eth_rx import eth_rx_pkg::*; ();

    localparam int CNT_WIDTH = 16;
    localparam int MAX_FRAME = 7 + 1 + 64 + 4 + 1;     // Preamble, SFD, payload, FCS, gap
    localparam int N_FRAMES  = 12;
    localparam int EXTRA     = 20 + 31 + 12 + 6 * 16;  // Reset, junk, runt, settling
    localparam int LIMIT     = 2 * (N_FRAMES * MAX_FRAME + EXTRA) + 200;

    logic                 clk;
    logic                 reset_n;
    rx_byte_t             rx_in;
    logic                 m_axis_valid;
    axis_beat_t           m_axis;
    logic [CNT_WIDTH-1:0] good_frames;
    logic [CNT_WIDTH-1:0] crc_err_frames;
    logic [CNT_WIDTH-1:0] phy_err_frames;
    logic [CNT_WIDTH-1:0] good_bytes;
    int                   seed     = 32'hb812;
    int                   cycles   = 0;
    int                   err_mark = 0;       // Error count at the start of a test

    eth_rx_top #(.CNT_WIDTH(CNT_WIDTH)) eth_rx_top_i (.*);
    rx_checker #(.CNT_WIDTH(CNT_WIDTH)) rx_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: stimulus still running after %0d cycles", LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic drive_byte(input byte_t data, input logic dv, input logic er);
        @(posedge clk);
        rx_in <= {data, dv, er};
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_byte(8'h00, 1'b0, 1'b0);
    endtask

    // dv-high bytes with no delimiter among them
    task automatic junk_bytes(input int n);
        byte_t b;
        repeat (n) begin
            b = byte_t'($random(seed));
            drive_byte((b == ETH_SFD) ? 8'h00 : b, 1'b1, 1'b0);
        end
    endtask

    function automatic int rand_len();
        return 5 + ($unsigned($random(seed)) % 60);
    endfunction

    // Preamble, SFD, random payload, FCS xor flip, one gap cycle
    task automatic eth_frame(input int pre, input int len, input int err_at, input crc_t flip);
        crc_t  crc;
        byte_t b;
        crc = CRC_INIT;
        repeat (pre) drive_byte(8'h55, 1'b1, 1'b0);
        drive_byte(ETH_SFD, 1'b1, 1'b0);
        for (int i = 0; i < len; i++) begin
            b = byte_t'($random(seed));
            drive_byte(b, 1'b1, i == err_at);
            crc = crc ^ {24'h0, b};
            repeat (8) crc = crc[0] ? ((crc >> 1) ^ CRC_POLY_REFL) : (crc >> 1);
        end
        crc = ~crc ^ flip;
        for (int i = 0; i < 4; i++)
            drive_byte(crc[8*i +: 8], 1'b1, 1'b0);     // LSB first
        idle_cycles(1);
    endtask

    task automatic finish_test(input int num, input string name);
        idle_cycles(16);
        @(negedge clk);
        $display("test %0d %s: %0d errors", num, name, rx_checker_i.errors - err_mark);
        err_mark = rx_checker_i.errors;
    endtask

    initial begin
        int len;
        rx_in   = '0;
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        idle_cycles(4);

        repeat (4) eth_frame(7, rand_len(), -1, '0);
        finish_test(1, "good frames");
        eth_frame(7, rand_len(), -1, 32'h1 << ($unsigned($random(seed)) % 32));
        finish_test(2, "flipped FCS bit");
        len = rand_len();
        eth_frame(7, len, $unsigned($random(seed)) % len, '0);
        finish_test(3, "PHY error mid-frame");

        junk_bytes(10);                                // Straight into the preamble
        eth_frame(2, rand_len(), -1, '0);
        junk_bytes(20);
        idle_cycles(1);
        eth_frame(7, rand_len(), -1, '0);
        finish_test(4, "junk and short preamble");

        repeat (3) eth_frame(7, rand_len(), -1, '0);   // Single gap cycle between frames
        repeat (7) drive_byte(8'h55, 1'b1, 1'b0);
        drive_byte(ETH_SFD, 1'b1, 1'b0);
        junk_bytes(3);                                 // Three-byte runt
        idle_cycles(1);
        eth_frame(7, rand_len(), -1, '0);
        finish_test(5, "back-to-back and runt");
        finish_test(6, "counter totals");

        $display("Summary: %0d checks, %0d errors", rx_checker_i.checks, rx_checker_i.errors);
        if (rx_checker_i.errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
